// File: sim.f
hw/pack_pkg.sv
hw/stream_reg_slice.sv
hw/sample_packer.sv
hw/packer_top.sv
verification/packer_tb.sv

// File: Makefile
# Verilator build for the sample packer
# make lint   static checks on all sources
# make sim    build, run and grade the testbench
# make clean  remove build output and log

TOP     = packer_tb
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

# the log decides the result, so a run that stops early fails too
sim:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "sim: PASS"; \
	else \
		echo "sim: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/packer_tb.sv
/* testbench for packer_top: clock, reset, random frames from a fixed seed,
   reference packing model, word checks and the final report */

`timescale 1ns/1ps

module packer_tb;

    import pack_pkg::*;

    localparam int TIMEOUT   = 2000;
    localparam int MAX_WORDS = 16;

    logic         clk;
    logic         reset;
    byte_order_e  order;
    sample_beat_t s_beat;
    logic         s_valid;
    logic         s_ready;
    word_beat_t   m_beat;
    logic         m_valid;
    logic         m_ready;

    integer seed;
    integer ready_seed;

    // expected output words and words per frame, in send order
    word_beat_t          exp_q[$];
    int                  len_q[$];
    logic [SAMPLE_W-1:0] frame_q[$];

    string test_name;
    int    errors;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    int    words_checked;
    int    test_words;
    int    frame_words;
    int    ready_gap;
    int    valid_gap;
    logic  stuck;

    packer_top uut (
        .clk     (clk),
        .reset   (reset),
        .order   (order),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic note_stuck();
        stuck = 1'b1;
        count_error();
    endtask

    // reference packing of frame_q into whole words
    task automatic model_frame(input byte_order_e ord);
        logic [WORD_W-1:0] words [0:MAX_WORDS-1];
        word_beat_t        w;
        int                n_words;
        int                p;
        n_words = (frame_q.size() * SAMPLE_W + WORD_W - 1) / WORD_W;
        for (int k = 0; k < MAX_WORDS; k++) begin
            words[k] = '0;
        end
        for (int i = 0; i < frame_q.size(); i++) begin
            for (int b = 0; b < SAMPLE_W; b++) begin
                if (ord == ORDER_BIG) begin
                    // stream runs from the msb of the first word downwards
                    p = i * SAMPLE_W + (SAMPLE_W - 1 - b);
                    words[p / WORD_W][WORD_W - 1 - p % WORD_W] = frame_q[i][b];
                end else begin
                    p = i * SAMPLE_W + b;
                    words[p / WORD_W][p % WORD_W] = frame_q[i][b];
                end
            end
        end
        for (int k = 0; k < n_words; k++) begin
            w.first = (k == 0);
            w.last  = (k == n_words - 1);
            w.data  = words[k];
            exp_q.push_back(w);
        end
        len_q.push_back(n_words);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !stuck) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout in %s: %0d expected words never arrived",
                         test_name, exp_q.size());
                note_stuck();
            end
        end
    endtask

    // holds the beat until the slice takes it
    task automatic drive_beat(input sample_beat_t beat);
        int waited;
        waited = 0;
        if (stuck) return;
        s_beat  = beat;
        s_valid = 1'b1;
        while (!s_ready) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout in %s: input beat was never accepted", test_name);
                note_stuck();
                s_valid = 1'b0;
                return;
            end
        end
        @(negedge clk);
        s_valid = 1'b0;
    endtask

    task automatic send_frame(input int n, input byte_order_e ord);
        sample_beat_t beat;
        int           gap;
        if (stuck) return;
        // order is latched with the first beat, so only change it when idle
        if (ord != order) begin
            wait_drain();
        end
        order = ord;
        frame_q.delete();
        for (int i = 0; i < n; i++) begin
            frame_q.push_back(SAMPLE_W'($random(seed)));
        end
        model_frame(ord);
        for (int i = 0; i < n; i++) begin
            beat.first = (i == 0);
            beat.last  = (i == n - 1);
            beat.data  = frame_q[i];
            drive_beat(beat);
            gap = 0;
            if (valid_gap > 0 && rand_below(100) < valid_gap) begin
                gap = 1 + rand_below(4);
            end
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_words  = 0;
    endtask

    task automatic end_test();
        wait_drain();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d words, %0d errors", test_name, test_words, test_errors);
    endtask

    task automatic check_word(input word_beat_t got);
        word_beat_t want;
        if (exp_q.size() == 0) begin
            $display("error in %s: word %h arrived with none expected", test_name, got);
            count_error();
            return;
        end
        want = exp_q.pop_front();
        words_checked++;
        test_words++;
        frame_words++;
        if (got !== want) begin
            $display("mismatch %s: expected %h actual %h", test_name, want, got);
            count_error();
        end
        if (got.last && len_q.size() != 0) begin
            if (frame_words != len_q[0]) begin
                $display("mismatch %s words per frame: expected %0d actual %0d",
                         test_name, len_q[0], frame_words);
                count_error();
            end
            void'(len_q.pop_front());
            frame_words = 0;
        end
    endtask

    // ------------------------------------------------------------
    // output side, m_ready owner and word checker
    // ------------------------------------------------------------

    initial begin
        m_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (reset) begin
                m_ready = 1'b0;
            end else if (ready_gap > 0) begin
                m_ready = ($unsigned($random(ready_seed)) % 100) >= ready_gap;
            end else begin
                m_ready = 1'b1;
            end
            // m_valid and m_beat are flop outputs, steady here
            if (m_valid && m_ready) begin
                check_word(m_beat);
            end
        end
    end

    // backstop for the whole run
    initial begin
        #2_000_000;
        $display("run exceeded its time limit");
        $display("Verification failed");
        $finish;
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        int waited;
        seed          = 22;
        ready_seed    = $random(seed);
        reset         = 1'b1;
        order         = ORDER_LITTLE;
        s_beat        = '0;
        s_valid       = 1'b0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        words_checked = 0;
        frame_words   = 0;
        ready_gap     = 0;
        valid_gap     = 0;
        stuck         = 1'b0;

        start_test("idle_after_reset");
        repeat (10) begin
            @(negedge clk);
            if (m_valid !== 1'b0) begin
                $display("error in %s: m_valid high during reset", test_name);
                count_error();
            end
        end
        reset  = 1'b0;
        waited = 0;
        while (s_ready !== 1'b1 && !stuck) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout in %s: s_ready never rose after reset", test_name);
                note_stuck();
            end
        end
        if (m_valid !== 1'b0) begin
            $display("error in %s: m_valid high right after reset", test_name);
            count_error();
        end
        end_test();

        start_test("little_order");
        repeat (20) send_frame(1 + rand_below(40), ORDER_LITTLE);
        end_test();

        start_test("big_order");
        repeat (20) send_frame(1 + rand_below(40), ORDER_BIG);
        end_test();

        // 16 samples fill five words exactly
        start_test("exact_fill");
        send_frame(16, ORDER_LITTLE);
        send_frame(16, ORDER_BIG);
        end_test();

        start_test("backpressure_gaps");
        valid_gap = 30;
        ready_gap = 40;
        repeat (30) begin
            send_frame(1 + rand_below(40), rand_below(2) ? ORDER_BIG : ORDER_LITTLE);
        end
        end_test();
        valid_gap = 0;
        ready_gap = 0;

        start_test("single_sample_frames");
        repeat (8) send_frame(1, ORDER_LITTLE);
        repeat (8) send_frame(1, ORDER_BIG);
        end_test();

        $display("tests run %0d, tests failed %0d, words checked %0d, errors %0d",
                 tests_run, tests_failed, words_checked, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: hw/packer_top.sv
/* top level of the sample packer: input slice, packer,
   output slice */

`timescale 1ns/1ps

module packer_top (
    input  logic                  clk,
    input  logic                  reset,
    input  pack_pkg::byte_order_e order,

    input  pack_pkg::sample_beat_t s_beat,
    input  logic                   s_valid,
    output logic                   s_ready,

    output pack_pkg::word_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);

    import pack_pkg::*;

    // slice to packer
    sample_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;

    // packer to slice
    word_beat_t   pk_beat;
    logic         pk_valid;
    logic         pk_ready;

    stream_reg_slice #(
        .item_t (sample_beat_t)
    ) in_slice (
        .clk     (clk),
        .reset   (reset),
        .s_item  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_item  (in_beat),
        .m_valid (in_valid),
        .m_ready (in_ready)
    );

    sample_packer packer (
        .clk     (clk),
        .reset   (reset),
        .order   (order),
        .s_beat  (in_beat),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .m_beat  (pk_beat),
        .m_valid (pk_valid),
        .m_ready (pk_ready)
    );

    stream_reg_slice #(
        .item_t (word_beat_t)
    ) out_slice (
        .clk     (clk),
        .reset   (reset),
        .s_item  (pk_beat),
        .s_valid (pk_valid),
        .s_ready (pk_ready),
        .m_item  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

// File: hw/sample_packer.sv
/* packs 10-bit sample beats into 32-bit words, per-frame order,
   zero padding of the final word and first/last marks */

`timescale 1ns/1ps

module sample_packer (
    input  logic                  clk,
    input  logic                  reset,
    input  pack_pkg::byte_order_e order,

    input  pack_pkg::sample_beat_t s_beat,
    input  logic                   s_valid,
    output logic                   s_ready,

    output pack_pkg::word_beat_t m_beat,
    output logic                 m_valid,
    input  logic                 m_ready
);

    import pack_pkg::*;

    // ------------------------------------------------------------
    // state
    // ------------------------------------------------------------

    pack_state_e        state_q;
    pack_state_e        state_n;
    logic [BUF_W-1:0]   buf_q;
    logic [BUF_W-1:0]   buf_n;
    logic [COUNT_W-1:0] count_q;
    logic [COUNT_W-1:0] count_n;
    byte_order_e        order_q;
    byte_order_e        order_n;

    // registered output marks
    logic               first_q;
    logic               first_n;
    logic               last_q;
    logic               last_n;
    logic               valid_n;

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------

    always_comb begin
        state_n = state_q;
        buf_n   = buf_q;
        count_n = count_q;
        order_n = order_q;
        first_n = first_q;
        last_n  = last_q;
        valid_n = m_valid;

        // word leaving this cycle
        if (m_ready) begin
            valid_n = 1'b0;
            if (m_valid) begin
                first_n = 1'b0;
                if (last_q) begin
                    // frame done
                    state_n = PK_IDLE;
                    count_n = '0;
                    buf_n   = '0;
                end else begin
                    if (order_q == ORDER_BIG) begin
                        buf_n = buf_n << WORD_W;
                    end else begin
                        buf_n = buf_n >> WORD_W;
                    end
                    count_n = count_n - COUNT_W'(WORD_W);
                end
            end
        end

        // room for one more sample, nothing left to drain
        s_ready = (state_n != PK_DRAIN) && (count_n <= COUNT_W'(BUF_W - SAMPLE_W));

        // sample arriving this cycle
        if (s_valid && s_ready) begin
            if (s_beat.first) begin
                // new frame, order is fixed from here on
                count_n = '0;
                buf_n   = '0;
                first_n = 1'b1;
                order_n = order;
            end

            if (s_beat.last) begin
                state_n = PK_DRAIN;
            end else begin
                state_n = PK_FILL;
            end

            if (order_n == ORDER_BIG) begin
                buf_n[BUF_W-1-count_n -: SAMPLE_W] = s_beat.data;
            end else begin
                buf_n[count_n +: SAMPLE_W] = s_beat.data;
            end
            count_n = count_n + COUNT_W'(SAMPLE_W);
        end

        // zero the unfilled part of the next word
        for (int i = 0; i < WORD_W; i++) begin
            if (i >= count_n) begin
                if (order_n == ORDER_BIG) begin
                    buf_n[BUF_W-1-i] = 1'b0;
                end else begin
                    buf_n[i] = 1'b0;
                end
            end
        end

        // a full word is ready, or the frame tail must go out
        if (count_n >= COUNT_W'(WORD_W) || state_n == PK_DRAIN) begin
            valid_n = 1'b1;
            last_n  = (state_n == PK_DRAIN) && (count_n <= COUNT_W'(WORD_W));
        end
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= PK_IDLE;
            count_q <= '0;
            order_q <= ORDER_LITTLE;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            state_q <= state_n;
            count_q <= count_n;
            order_q <= order_n;
            first_q <= first_n;
            last_q  <= last_n;
            m_valid <= valid_n;
        end
    end

    always_ff @(posedge clk) begin
        buf_q <= buf_n;
    end

    // ------------------------------------------------------------
    // output word
    // ------------------------------------------------------------

    // big order sends from the top of the buffer
    always_comb begin
        m_beat.first = first_q;
        m_beat.last  = last_q;
        if (order_q == ORDER_BIG) begin
            m_beat.data = buf_q[BUF_W-1 -: WORD_W];
        end else begin
            m_beat.data = buf_q[WORD_W-1:0];
        end
    end

    a_count_range : assert property (
        @(posedge clk) disable iff (reset)
        count_q <= COUNT_W'(BUF_W)
    );

    // no new sample may disturb a word that is waiting
    a_word_hold : assert property (
        @(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_beat)
    );

endmodule

// File: hw/stream_reg_slice.sv
/* two-entry register slice for a valid/ready stream,
   main register plus skid register, ready from a flop */

`timescale 1ns/1ps

module stream_reg_slice #(
    parameter type item_t = logic
) (
    input  logic  clk,
    input  logic  reset,

    input  item_t s_item,
    input  logic  s_valid,
    output logic  s_ready,

    output item_t m_item,
    output logic  m_valid,
    input  logic  m_ready
);

    // skid entry catches the item taken while the output stalls
    item_t skid_item;
    logic  skid_valid;

    logic  out_free;
    logic  in_take;

    // main register can load this cycle
    assign out_free = m_ready || !m_valid;
    assign in_take  = s_valid && s_ready;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
            s_ready    <= 1'b0;
        end else if (out_free) begin
            // skid drains first; input is blocked while skid is full
            m_valid    <= skid_valid || in_take;
            skid_valid <= 1'b0;
            s_ready    <= 1'b1;
        end else if (in_take) begin
            // output stuck, park the new item and close the input
            skid_valid <= 1'b1;
            s_ready    <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (out_free) begin
            m_item <= skid_valid ? skid_item : s_item;
        end else if (in_take) begin
            skid_item <= s_item;
        end
    end

    // held item must not change until it is taken
    a_hold_item : assert property (
        @(posedge clk) disable iff (reset)
        m_valid && !m_ready |=> m_valid && $stable(m_item)
    );

endmodule

// File: hw/pack_pkg.sv
/* widths, stream beat structs and the enums shared by the
   sample to word packer */

package pack_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------

    // one sensor sample on the input stream
    localparam int SAMPLE_W = 10;

    // one packed word on the output stream
    localparam int WORD_W = 32;

    // worst case fill is one word less one bit, plus one sample
    localparam int BUF_W = SAMPLE_W + WORD_W - 1;

    // fill counter must hold BUF_W itself
    localparam int COUNT_W = $clog2(BUF_W + 1);

    // ------------------------------------------------------------
    // enums
    // ------------------------------------------------------------

    // which end of the word takes the first sample
    typedef enum logic {
        ORDER_LITTLE = 1'b0,
        ORDER_BIG    = 1'b1
    } byte_order_e;

    // frame state of the packer
    typedef enum logic [1:0] {
        PK_IDLE  = 2'd0,
        PK_FILL  = 2'd1,
        PK_DRAIN = 2'd2
    } pack_state_e;

    // ------------------------------------------------------------
    // stream beats
    // ------------------------------------------------------------

    // input beat, first/last mark the frame edges
    typedef struct packed {
        logic                first;
        logic                last;
        logic [SAMPLE_W-1:0] data;
    } sample_beat_t;

    // output beat with its own frame marks
    typedef struct packed {
        logic              first;
        logic              last;
        logic [WORD_W-1:0] data;
    } word_beat_t;

endpackage
